//--- Bender.yml
package:
  name: mips_cpu_harvard

sources:
  - common/mips_isa_pkg.sv
  - common/mips_cpu_pkg.sv
  - common/ctrl_if.sv
  - src/datapath/alu.sv
  - src/datapath/regfile.sv
  - src/datapath/datapath.sv
  - src/fetch/instr_fetch.sv
  - src/decoder.sv
  - src/mips_cpu_harvard.sv
  - target: test
    files:
      - tests/cpu_checker.sv
      - tests/tb_mips_cpu.sv

//--- common/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if
    import mips_cpu_pkg::*;
();

    logic     reg_dst;
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    alu_op_t  alu_op;
    opb_sel_t opb_sel;
    next_pc_t next_pc;
    logic     branch_ne;

    modport dec (
        output reg_dst, reg_write, mem_read, mem_write, mem_to_reg,
        output alu_op, opb_sel, next_pc, branch_ne
    );

    modport dp (
        input reg_dst, reg_write, mem_read, mem_write, mem_to_reg,
        input alu_op, opb_sel
    );

    modport fetch (
        input next_pc, branch_ne
    );

endinterface

//--- common/mips_cpu_pkg.sv
package mips_cpu_pkg;

    // ALU operations
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SLTU = 3'd5
    } alu_op_t;

    // Second ALU operand
    typedef enum logic [1:0] {
        OPB_REG  = 2'd0,
        OPB_SEXT = 2'd1,
        OPB_ZEXT = 2'd2
    } opb_sel_t;

    // Next PC source
    typedef enum logic [1:0] {
        NPC_SEQ    = 2'd0,
        NPC_BRANCH = 2'd1,
        NPC_JUMP   = 2'd2,
        NPC_REG    = 2'd3
    } next_pc_t;

endpackage

//--- common/mips_isa_pkg.sv
package mips_isa_pkg;

    // Instruction word fields, one struct per MIPS format
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_fields_t;

    // Same 32-bit word seen through each format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

    // Opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0C;
    localparam logic [5:0] OP_ORI     = 6'h0D;
    localparam logic [5:0] OP_XORI    = 6'h0E;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2B;

    // SPECIAL function codes
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLTU = 6'h2B;

    // Boot vector in kseg1
    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;

    // A JR here stops the CPU
    localparam logic [31:0] HALT_ADDR = 32'h00000000;

    localparam logic [4:0] REG_V0 = 5'd2;

endpackage

//--- src.f
common/mips_isa_pkg.sv
common/mips_cpu_pkg.sv
common/ctrl_if.sv
src/datapath/alu.sv
src/datapath/regfile.sv
src/datapath/datapath.sv
src/fetch/instr_fetch.sv
src/decoder.sv
src/mips_cpu_harvard.sv
tests/cpu_checker.sv
tests/tb_mips_cpu.sv

//--- src/datapath/alu.sv
`timescale 1ns/1ns

module alu
    import mips_cpu_pkg::*;
(
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            // Unsigned compare
            ALU_SLTU: result = {31'h0, (a < b)};
            default:  result = 32'h0;
        endcase
    end

    assign zero = (result == 32'h0);

endmodule

//--- src/datapath/datapath.sv
`timescale 1ns/1ns

module datapath
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        run,
    input  logic        clk_enable,
    input  logic        active,
    input  instr_t      instr_readdata,
    ctrl_if.dp          ctrl,
    input  logic [31:0] data_readdata,
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    output logic        alu_zero,
    output logic [31:0] rs_data,
    output logic [31:0] register_v0
);

    logic [31:0] rt_data;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] opb;
    logic [31:0] alu_result;
    logic [31:0] wb_data;
    logic [4:0]  wb_index;
    logic        wb_enable;

    assign imm_sext = {{16{instr_readdata.i.imm[15]}}, instr_readdata.i.imm};
    assign imm_zext = {16'h0000, instr_readdata.i.imm};

    always_comb begin
        case (ctrl.opb_sel)
            OPB_SEXT: opb = imm_sext;
            OPB_ZEXT: opb = imm_zext;
            default:  opb = rt_data;
        endcase
    end

    alu alu0 (
        .op     (ctrl.alu_op),
        .a      (rs_data),
        .b      (opb),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // Write-back
    assign wb_index  = ctrl.reg_dst ? instr_readdata.r.rd : instr_readdata.r.rt;
    assign wb_data   = ctrl.mem_to_reg ? data_readdata : alu_result;
    assign wb_enable = ctrl.reg_write && run;

    regfile regfile0 (
        .clk          (clk),
        .reset        (reset),
        .write_enable (wb_enable),
        .read_index_a (instr_readdata.r.rs),
        .read_index_b (instr_readdata.r.rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_data_a  (rs_data),
        .read_data_b  (rt_data),
        .register_v0  (register_v0)
    );

    // Data port, quiet while halted or in reset
    assign data_address   = alu_result;
    assign data_writedata = rt_data;
    assign data_write     = ctrl.mem_write && active && clk_enable && !reset;
    assign data_read      = ctrl.mem_read && active && !reset;

endmodule

//--- src/datapath/regfile.sv
`timescale 1ns/1ns

module regfile
    import mips_isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        write_enable,
    input  logic [4:0]  read_index_a,
    input  logic [4:0]  read_index_b,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data,
    output logic [31:0] read_data_a,
    output logic [31:0] read_data_b,
    output logic [31:0] register_v0
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (write_enable && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // $zero is hardwired
    assign read_data_a = (read_index_a == 5'd0) ? 32'h0 : regs[read_index_a];
    assign read_data_b = (read_index_b == 5'd0) ? 32'h0 : regs[read_index_b];

    assign register_v0 = regs[REG_V0];

endmodule

//--- src/decoder.sv
`timescale 1ns/1ns

module decoder
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;
(
    input instr_t instr_readdata,
    ctrl_if.dec   ctrl
);

    always_comb begin
        // No-op unless the encoding is recognised
        ctrl.reg_dst    = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.alu_op     = ALU_ADD;
        ctrl.opb_sel    = OPB_REG;
        ctrl.next_pc    = NPC_SEQ;
        ctrl.branch_ne  = 1'b0;

        case (instr_readdata.r.opcode)
            OP_SPECIAL: begin
                ctrl.reg_dst = 1'b1;
                case (instr_readdata.r.funct)
                    FN_ADDU: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_ADD;
                    end
                    FN_SUBU: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_SUB;
                    end
                    FN_AND: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_AND;
                    end
                    FN_OR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_OR;
                    end
                    FN_XOR: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_XOR;
                    end
                    FN_SLTU: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALU_SLTU;
                    end
                    FN_JR: ctrl.next_pc = NPC_REG;
                    default: ;
                endcase
            end
            OP_ADDIU: begin
                ctrl.reg_write = 1'b1;
                ctrl.opb_sel   = OPB_SEXT;
            end
            OP_ANDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_AND;
                ctrl.opb_sel   = OPB_ZEXT;
            end
            OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
                ctrl.opb_sel   = OPB_ZEXT;
            end
            OP_XORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_XOR;
                ctrl.opb_sel   = OPB_ZEXT;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.opb_sel    = OPB_SEXT;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.opb_sel   = OPB_SEXT;
            end
            // Compare rs with rt through the subtractor
            OP_BEQ: begin
                ctrl.alu_op  = ALU_SUB;
                ctrl.next_pc = NPC_BRANCH;
            end
            OP_BNE: begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.next_pc   = NPC_BRANCH;
                ctrl.branch_ne = 1'b1;
            end
            OP_J: ctrl.next_pc = NPC_JUMP;
            default: ;
        endcase
    end

endmodule

//--- src/fetch/instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  instr_t      instr_readdata,
    ctrl_if.fetch       ctrl,
    input  logic        alu_zero,
    input  logic [31:0] rs_data,
    output logic [31:0] instr_address,
    output logic        active,
    output logic        run
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] branch_offset;
    logic [31:0] next_pc;
    logic        branch_taken;
    logic        halt;

    assign pc_plus4 = pc + 32'd4;

    // Word offset, sign-extended
    assign branch_offset = {{14{instr_readdata.i.imm[15]}}, instr_readdata.i.imm, 2'b00};

    // BEQ wants zero, BNE wants non-zero
    assign branch_taken = alu_zero ^ ctrl.branch_ne;

    always_comb begin
        case (ctrl.next_pc)
            NPC_BRANCH: next_pc = branch_taken ? pc_plus4 + branch_offset : pc_plus4;
            NPC_JUMP:   next_pc = {pc_plus4[31:28], instr_readdata.j.target, 2'b00};
            NPC_REG:    next_pc = rs_data;
            default:    next_pc = pc_plus4;
        endcase
    end

    assign halt = (ctrl.next_pc == NPC_REG) && (rs_data == HALT_ADDR);

    assign run = clk_enable && active && !reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_VECTOR;
            active <= 1'b1;
        end else if (run) begin
            pc <= next_pc;
            if (halt) begin
                active <= 1'b0;
            end
        end
    end

    assign instr_address = pc;

endmodule

//--- src/mips_cpu_harvard.sv
`timescale 1ns/1ns

module mips_cpu_harvard (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    output logic        active,
    output logic [31:0] register_v0,

    // Instruction port, combinational read
    output logic [31:0] instr_address,
    input  logic [31:0] instr_readdata,

    // Data port, combinational read and single-cycle write
    output logic [31:0] data_address,
    output logic        data_write,
    output logic        data_read,
    output logic [31:0] data_writedata,
    input  logic [31:0] data_readdata
);

    logic        run;
    logic        alu_zero;
    logic [31:0] rs_data;

    ctrl_if ctrl ();

    instr_fetch fetch0 (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .instr_readdata (instr_readdata),
        .ctrl           (ctrl.fetch),
        .alu_zero       (alu_zero),
        .rs_data        (rs_data),
        .instr_address  (instr_address),
        .active         (active),
        .run            (run)
    );

    decoder decoder0 (
        .instr_readdata (instr_readdata),
        .ctrl           (ctrl.dec)
    );

    datapath datapath0 (
        .clk            (clk),
        .reset          (reset),
        .run            (run),
        .clk_enable     (clk_enable),
        .active         (active),
        .instr_readdata (instr_readdata),
        .ctrl           (ctrl.dp),
        .data_readdata  (data_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .alu_zero       (alu_zero),
        .rs_data        (rs_data),
        .register_v0    (register_v0)
    );

endmodule

//--- tests/cpu_checker.sv
`timescale 1ns/1ns

module cpu_checker
    import mips_isa_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        clk_enable,
    input logic        active,
    input logic [31:0] instr_address,
    input logic        data_write,
    input logic        data_read,
    input logic [31:0] data_address,
    input logic [31:0] data_writedata,
    input logic [31:0] register_v0
);

    int          write_count;
    int          read_count;
    int          late_writes;
    logic [31:0] last_addr;
    logic [31:0] last_data;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_errors;

    // Data port activity as memory sees it at the edge
    always @(posedge clk) begin
        if (!reset && data_write) begin
            write_count <= write_count + 1;
            last_addr   <= data_address;
            last_data   <= data_writedata;
            if (!active) begin
                late_writes <= late_writes + 1;
            end
        end
        // One read per retired load
        if (!reset && data_read && clk_enable) begin
            read_count <= read_count + 1;
        end
    end

    task automatic clear_activity();
        write_count <= 0;
        read_count  <= 0;
        late_writes <= 0;
        last_addr   <= 32'h0;
        last_data   <= 32'h0;
        test_errors = 0;
    endtask

    task automatic report_value(input string name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s %s expected %h actual %h", name, what, expected, actual);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic check_reset_state(input string name);
        report_value(name, "reset pc", RESET_VECTOR, instr_address);
        report_value(name, "reset active", 32'd1, {31'h0, active});
        report_value(name, "reset data_write", 32'd0, {31'h0, data_write});
        report_value(name, "reset data_read", 32'd0, {31'h0, data_read});
    endtask

    task automatic compare(input string name, input logic [31:0] exp_v0, input int exp_writes,
                           input int exp_reads, input logic [31:0] exp_addr,
                           input logic [31:0] exp_data);
        report_value(name, "v0", exp_v0, register_v0);
        report_value(name, "writes", exp_writes, write_count);
        report_value(name, "reads", exp_reads, read_count);
        if (exp_writes > 0) begin
            report_value(name, "write addr", exp_addr, last_addr);
            report_value(name, "write data", exp_data, last_data);
        end
        // Halted CPU parks at the halt address
        report_value(name, "halt pc", HALT_ADDR, instr_address);
        report_value(name, "halt active", 32'd0, {31'h0, active});
        if (late_writes != 0) begin
            $display("%s: data memory was written after the CPU halted", name);
            test_errors++;
            error_count++;
        end
        if (test_errors == 0) begin
            $display("ok    %s", name);
            pass_count++;
        end else begin
            $display("fail  %s", name);
            fail_count++;
        end
    endtask

    task automatic report_counts();
        $display("%0d tests passed, %0d failed, %0d errors", pass_count, fail_count,
                 error_count);
    endtask

endmodule

//--- tests/tb_mips_cpu.sv
`timescale 1ns/1ns

module tb_mips_cpu
    import mips_isa_pkg::*;
();

    localparam int NUM_TESTS = 17;
    localparam int PROG_WORDS = 12;
    // Instructions times cycles per instruction, with reset slack
    localparam longint TIMEOUT_NS = NUM_TESTS * (PROG_WORDS * 4 + 8) * 8;

    logic        clk = 1'b0;
    logic        reset;
    logic        clk_enable;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] instr_readdata;
    logic [31:0] data_address;
    logic        data_write;
    logic        data_read;
    logic [31:0] data_writedata;
    logic [31:0] data_readdata;

    integer      seed = 32'h7709;
    logic [31:0] rnd;
    logic        rand_enable = 1'b0;

    logic [31:0] imem [0:PROG_WORDS-1];
    logic [31:0] dmem [0:15];
    logic [31:0] imem_off;

    // Test table
    string       names [0:NUM_TESTS-1];
    logic [31:0] progs [0:NUM_TESTS-1][0:PROG_WORDS-1];
    logic [31:0] exp_v0 [0:NUM_TESTS-1];
    int          exp_writes [0:NUM_TESTS-1];
    int          exp_reads [0:NUM_TESTS-1];
    logic [31:0] exp_addr [0:NUM_TESTS-1];
    logic [31:0] exp_data [0:NUM_TESTS-1];
    logic        exp_rand_en [0:NUM_TESTS-1];
    logic [31:0] prog_buf [0:PROG_WORDS-1];
    int          buf_len;
    int          n_tests = 0;

    always #4 clk = ~clk;

    mips_cpu_harvard dut0 (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_writedata (data_writedata),
        .data_readdata  (data_readdata)
    );

    cpu_checker checker0 (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .instr_address  (instr_address),
        .data_write     (data_write),
        .data_read      (data_read),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .register_v0    (register_v0)
    );

    // Fetches outside the program see a store of v0
    assign imem_off       = instr_address - RESET_VECTOR;
    assign instr_readdata = (imem_off < PROG_WORDS * 4) ? imem[imem_off[5:2]]
                                                        : {OP_SW, 5'd0, REG_V0, 16'h0};
    assign data_readdata  = dmem[data_address[5:2]];

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_address[5:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        rnd = $random(seed);
        clk_enable <= rand_enable ? rnd[0] : 1'b1;
    end

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd);
        instr_t w;
        w.r = '{OP_SPECIAL, rs, rt, rd, 5'd0, funct};
        return w;
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        instr_t w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    task automatic push_word(input logic [31:0] w);
        prog_buf[buf_len] = w;
        buf_len++;
    endtask

    // Appends the halt sequence and stores the program as a table row
    task automatic commit(input string name, input logic [31:0] v0, input int nw, input int nr,
                          input logic [31:0] addr, input logic [31:0] data, input logic en);
        push_word(rtype_word(FN_ADDU, 5'd0, 5'd0, 5'd9));
        push_word(rtype_word(FN_JR, 5'd9, 5'd0, 5'd0));
        for (int k = 0; k < PROG_WORDS; k++) begin
            progs[n_tests][k] = (k < buf_len) ? prog_buf[k] : 32'h0;
        end
        names[n_tests]       = name;
        exp_v0[n_tests]      = v0;
        exp_writes[n_tests]  = nw;
        exp_reads[n_tests]   = nr;
        exp_addr[n_tests]    = addr;
        exp_data[n_tests]    = data;
        exp_rand_en[n_tests] = en;
        n_tests++;
        buf_len = 0;
    endtask

    task automatic build_table();
        logic [5:0]  r_fn [0:5];
        logic [5:0]  i_op [0:3];
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] res;
        r_fn = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLTU};
        i_op = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI};
        buf_len = 0;
        for (int k = 0; k < 6; k++) begin
            a = $random(seed);
            b = $random(seed);
            x = sext(a);
            y = sext(b);
            case (k)
                0: res = x + y;
                1: res = x - y;
                2: res = x & y;
                3: res = x | y;
                4: res = x ^ y;
                default: res = (x < y) ? 32'd1 : 32'd0;
            endcase
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd1, a));
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd3, b));
            push_word(rtype_word(r_fn[k], 5'd1, 5'd3, 5'd2));
            commit($sformatf("rtype_%0d", k), res, 0, 0, 0, 0, 1'b0);
        end
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            x = sext(a);
            // Logical immediates are zero-extended
            case (k)
                0: res = x + sext(b);
                1: res = x & {16'h0, b};
                2: res = x | {16'h0, b};
                default: res = x ^ {16'h0, b};
            endcase
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd1, a));
            push_word(itype_word(i_op[k], 5'd1, 5'd2, b));
            commit($sformatf("itype_%0d", k), res, 0, 0, 0, 0, 1'b0);
        end
        a = $random(seed);
        for (int k = 0; k < 2; k++) begin
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd5, a));
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd6, 16'd8));
            push_word(itype_word(OP_SW, 5'd6, 5'd5, 16'd4));
            push_word(itype_word(OP_LW, 5'd6, 5'd2, 16'd4));
            commit(k == 0 ? "sw_lw" : "sw_lw_clk_enable", sext(a), 1, 1, 32'd12, sext(a),
                   k == 1);
        end
        // Taken BEQ skips one word, untaken BNE falls through
        for (int k = 0; k < 2; k++) begin
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd1, 16'd5));
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd3, 16'd5));
            push_word(itype_word(k == 0 ? OP_BEQ : OP_BNE, 5'd1, 5'd3, 16'd1));
            push_word(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd1));
            push_word(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd7));
            commit(k == 0 ? "beq_taken" : "bne_not_taken", k == 0 ? 32'd7 : 32'd8, 0, 0, 0, 0,
                   1'b0);
        end
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd1, 16'd3));
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd0));
        push_word(itype_word(OP_ADDIU, 5'd2, 5'd2, 16'd5));
        push_word(itype_word(OP_ADDIU, 5'd1, 5'd1, 16'hFFFF));
        push_word(itype_word(OP_BNE, 5'd1, 5'd0, 16'hFFFD));
        commit("bne_loop", 32'd15, 0, 0, 0, 0, 1'b0);
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd9));
        x = (RESET_VECTOR + 32'd12) >> 2;
        push_word({OP_J, x[25:0]});
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd1));
        commit("jump", 32'd9, 0, 0, 0, 0, 1'b0);
        a = $random(seed) | 16'h1;
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd0, a));
        push_word(itype_word(OP_ADDIU, 5'd0, 5'd2, 16'd7));
        push_word(rtype_word(FN_ADDU, 5'd2, 5'd0, 5'd2));
        commit("reg_zero", 32'd7, 0, 0, 0, 0, 1'b0);
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired: the CPU did not halt in time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        clk_enable = 1'b1;
        for (int k = 0; k < PROG_WORDS; k++) begin
            imem[k] = 32'h0;
        end
        build_table();
        if (n_tests != NUM_TESTS) begin
            $display("Test table holds %0d entries instead of %0d", n_tests, NUM_TESTS);
        end
        for (int t = 0; t < n_tests; t++) begin
            @(posedge clk);
            reset       <= 1'b1;
            rand_enable <= exp_rand_en[t];
            for (int k = 0; k < PROG_WORDS; k++) begin
                imem[k] = progs[t][k];
            end
            for (int k = 0; k < 16; k++) begin
                dmem[k] <= {16'hD0A0, 10'h0, k[3:0], 2'b00};
            end
            checker0.clear_activity();
            repeat (2) @(posedge clk);
            reset <= 1'b0;
            @(negedge clk);
            checker0.check_reset_state(names[t]);
            while (active) begin
                @(posedge clk);
            end
            // A few idle edges to catch activity after halt
            repeat (3) @(posedge clk);
            @(negedge clk);
            checker0.compare(names[t], exp_v0[t], exp_writes[t], exp_reads[t], exp_addr[t],
                             exp_data[t]);
        end
        checker0.report_counts();
        if (checker0.error_count == 0 && n_tests == NUM_TESTS) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
